// File: verilog/tx_rst_types_pkg.sv
/* Tx reset sequencer types */

`default_nettype none

package tx_rst_types_pkg;

    // Transceiver lanes served by one sequencer
    localparam int NUM_LANES = 4;

    // One bit per lane
    typedef logic [NUM_LANES-1:0] lane_vec_t;

    // Tx clock divider rate code
    typedef logic [2:0] ckdiv_t;

    // Lane reset sequence
    typedef enum logic [2:0] {
        ST_PWRDN     = 3'd0,
        ST_WAIT_LOCK = 3'd1,
        ST_LANE_SYNC = 3'd2,
        ST_PMA_RST   = 3'd3,
        ST_PCS_RST   = 3'd4,
        ST_DONE      = 3'd5,
        ST_RATE_CHG  = 3'd6
    } lane_state_t;

endpackage

`default_nettype wire

// File: verilog/tx_rst_timing_pkg.sv
/* Tx reset step timing */

`default_nettype none

package tx_rst_timing_pkg;

    typedef logic [7:0] tmr_t;

    // Step lengths in clk cycles
    localparam tmr_t PD_RELEASE_CYCLES  = 8'd16;
    localparam tmr_t LANE_SYNC_CYCLES   = 8'd8;
    localparam tmr_t PMA_RST_CYCLES     = 8'd16;
    localparam tmr_t PCS_RST_CYCLES     = 8'd8;
    localparam tmr_t RATE_SETTLE_CYCLES = 8'd8;

endpackage

`default_nettype wire

// File: verilog/hsst_tx_lane_if.sv
/* Tx lane control bundle */

`timescale 1ns/1ps
`default_nettype none

interface hsst_tx_lane_if import tx_rst_types_pkg::*; ();

    // Power-downs, active high
    logic   pd_clkpath;
    logic   pd_driver;
    logic   pd_piso;
    ckdiv_t tx_rate;
    logic   pma_rst;
    logic   pcs_rst;
    // Toward the PLL0 combine
    logic   lane_sync;
    logic   rate_change_on;

    modport fsm (
        output pd_clkpath, pd_driver, pd_piso, tx_rate,
        output pma_rst, pcs_rst, lane_sync, rate_change_on
    );

    modport mon (
        input pd_clkpath, pd_driver, pd_piso, tx_rate,
        input pma_rst, pcs_rst, lane_sync, rate_change_on
    );

endinterface

`default_nettype wire

// File: verilog/lane_input_cond.sv
/* Lane input conditioning */

`timescale 1ns/1ps
`default_nettype none

module lane_input_cond #(
    parameter int LOCK_DEB_CYCLES = 2048
) (
    input  wire  clk,
    input  wire  i_pll_done_0,
    input  wire  i_txlane_rst,
    input  wire  i_pll_lock_tx,
    input  wire  i_tx_rate_chng,
    output logic o_lane_rstn,
    output logic o_lock_deb,
    output logic o_rate_req
);

    localparam int DEB_W = $clog2(LOCK_DEB_CYCLES);
    localparam logic [DEB_W-1:0] DEB_LAST = DEB_W'(LOCK_DEB_CYCLES - 1);

    wire              rst_async_n;
    logic             rst_meta;
    logic             lock_meta;
    logic             lock_s;
    logic             rate_meta;
    logic [DEB_W-1:0] deb_cnt;

    // Asserts at once, releases two clocks later
    assign rst_async_n = i_pll_done_0 & ~i_txlane_rst;

    always_ff @(posedge clk or negedge rst_async_n) begin
        if (!rst_async_n) begin
            rst_meta    <= 1'b0;
            o_lane_rstn <= 1'b0;
        end else begin
            rst_meta    <= 1'b1;
            o_lane_rstn <= rst_meta;
        end
    end

    always_ff @(posedge clk or negedge o_lane_rstn) begin
        if (!o_lane_rstn) begin
            lock_meta  <= 1'b0;
            lock_s     <= 1'b0;
            rate_meta  <= 1'b0;
            o_rate_req <= 1'b0;
        end else begin
            lock_meta  <= i_pll_lock_tx;
            lock_s     <= lock_meta;
            rate_meta  <= i_tx_rate_chng;
            o_rate_req <= rate_meta;
        end
    end

    // Lock must hold for the full count, any drop restarts it
    always_ff @(posedge clk or negedge o_lane_rstn) begin
        if (!o_lane_rstn) begin
            deb_cnt    <= '0;
            o_lock_deb <= 1'b0;
        end else if (!lock_s) begin
            deb_cnt    <= '0;
            o_lock_deb <= 1'b0;
        end else if (deb_cnt == DEB_LAST) begin
            o_lock_deb <= 1'b1;
        end else begin
            deb_cnt <= deb_cnt + 1'b1;
        end
    end

    // Rises only once the synchronized lock has held for the full count
    a_deb_hold_time : assert property (
        @(posedge clk) disable iff (!o_lane_rstn)
        $rose(o_lock_deb) |-> $past(lock_s, LOCK_DEB_CYCLES)
    );

endmodule

`default_nettype wire

// File: verilog/txlane_rst_fsm.sv
/* Tx lane reset state machine */

`timescale 1ns/1ps
`default_nettype none

module txlane_rst_fsm import tx_rst_types_pkg::*, tx_rst_timing_pkg::*; #(
    parameter ckdiv_t DEFAULT_CKDIV = '0
) (
    input  wire            clk,
    input  wire            i_rst_n,
    input  wire            i_lock_deb,
    input  wire            i_rate_req,
    input  wire ckdiv_t    i_txckdiv,
    output logic           o_txlane_done,
    output logic           o_txckdiv_done,
    hsst_tx_lane_if.fsm    lane
);

    lane_state_t state;
    tmr_t        tmr;
    tmr_t        step_len;
    logic        step_end;
    logic        rate_req_q;
    logic        rate_rise;
    logic        lock_lost;
    ckdiv_t      new_rate;

    ////////////////////////////////////////
    // Step timing
    ////////////////////////////////////////

    always_comb begin
        unique case (state)
            ST_PWRDN:     step_len = PD_RELEASE_CYCLES;
            ST_LANE_SYNC: step_len = LANE_SYNC_CYCLES;
            ST_PMA_RST:   step_len = PMA_RST_CYCLES;
            ST_PCS_RST:   step_len = PCS_RST_CYCLES;
            ST_RATE_CHG:  step_len = RATE_SETTLE_CYCLES;
            default:      step_len = '0;
        endcase
    end

    assign step_end  = (tmr == tmr_t'(step_len - 8'd1));
    assign rate_rise = i_rate_req & ~rate_req_q;
    // Only counts once the lane has seen lock
    assign lock_lost = !i_lock_deb && (state != ST_PWRDN) && (state != ST_WAIT_LOCK);

    // New rate waits here until the settle time is over
    always_ff @(posedge clk) begin
        if ((state == ST_DONE) && rate_rise) begin
            new_rate <= i_txckdiv;
        end
    end

    ////////////////////////////////////////
    // Sequence
    ////////////////////////////////////////

    always_ff @(posedge clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            state               <= ST_PWRDN;
            tmr                 <= '0;
            rate_req_q          <= 1'b0;
            lane.pd_clkpath     <= 1'b1;
            lane.pd_driver      <= 1'b1;
            lane.pd_piso        <= 1'b1;
            lane.tx_rate        <= DEFAULT_CKDIV;
            lane.pma_rst        <= 1'b1;
            lane.pcs_rst        <= 1'b1;
            lane.lane_sync      <= 1'b0;
            lane.rate_change_on <= 1'b1;
            o_txlane_done       <= 1'b0;
            o_txckdiv_done      <= 1'b0;
        end else begin
            rate_req_q <= i_rate_req;
            if (lock_lost) begin
                // Power stays up and the rate is kept
                state               <= ST_WAIT_LOCK;
                tmr                 <= '0;
                lane.pma_rst        <= 1'b1;
                lane.pcs_rst        <= 1'b1;
                lane.lane_sync      <= 1'b0;
                lane.rate_change_on <= 1'b1;
                o_txlane_done       <= 1'b0;
            end else begin
                unique case (state)
                    ST_PWRDN: begin
                        if (step_end) begin
                            lane.pd_clkpath <= 1'b0;
                            lane.pd_driver  <= 1'b0;
                            lane.pd_piso    <= 1'b0;
                            tmr             <= '0;
                            state           <= ST_WAIT_LOCK;
                        end else begin
                            tmr <= tmr + 1'b1;
                        end
                    end
                    ST_WAIT_LOCK: begin
                        if (i_lock_deb) begin
                            lane.lane_sync <= 1'b1;
                            tmr            <= '0;
                            state          <= ST_LANE_SYNC;
                        end
                    end
                    ST_LANE_SYNC: begin
                        if (step_end) begin
                            lane.lane_sync <= 1'b0;
                            tmr            <= '0;
                            state          <= ST_PMA_RST;
                        end else begin
                            tmr <= tmr + 1'b1;
                        end
                    end
                    ST_PMA_RST: begin
                        if (step_end) begin
                            lane.pma_rst <= 1'b0;
                            tmr          <= '0;
                            state        <= ST_PCS_RST;
                        end else begin
                            tmr <= tmr + 1'b1;
                        end
                    end
                    ST_PCS_RST: begin
                        if (step_end) begin
                            lane.pcs_rst  <= 1'b0;
                            o_txlane_done <= 1'b1;
                            tmr           <= '0;
                            state         <= ST_DONE;
                        end else begin
                            tmr <= tmr + 1'b1;
                        end
                    end
                    ST_DONE: begin
                        if (rate_rise) begin
                            lane.pcs_rst        <= 1'b1;
                            lane.rate_change_on <= 1'b0;
                            o_txlane_done       <= 1'b0;
                            o_txckdiv_done      <= 1'b0;
                            tmr                 <= '0;
                            state               <= ST_RATE_CHG;
                        end
                    end
                    ST_RATE_CHG: begin
                        if (step_end) begin
                            lane.tx_rate        <= new_rate;
                            lane.rate_change_on <= 1'b1;
                            o_txckdiv_done      <= 1'b1;
                            tmr                 <= '0;
                            state               <= ST_PCS_RST;
                        end else begin
                            tmr <= tmr + 1'b1;
                        end
                    end
                    default: begin
                        tmr   <= '0;
                        state <= ST_PWRDN;
                    end
                endcase
            end
        end
    end

    a_pcs_after_pma : assert property (
        @(posedge clk) disable iff (!i_rst_n)
        lane.pma_rst |-> lane.pcs_rst
    );

    a_done_out_of_rst : assert property (
        @(posedge clk) disable iff (!i_rst_n)
        o_txlane_done |-> (!lane.pma_rst && !lane.pcs_rst)
    );

endmodule

`default_nettype wire

// File: verilog/pll_sync_combine.sv
/* PLL0 sync and rate-change combine */

`timescale 1ns/1ps
`default_nettype none

module pll_sync_combine import tx_rst_types_pkg::*; #(
    parameter lane_vec_t LANE_ENABLE = '1
) (
    input  wire            clk,
    input  wire            i_pll_done_0,
    input  wire lane_vec_t i_lane_sync,
    input  wire lane_vec_t i_rate_change_on,
    output logic           o_lane_sync,
    output logic           o_rate_change_tclk_on
);

    wire  sync_any;
    wire  rc_all;
    logic sync_ff;
    logic rc_ff;

    // Removed lanes count as idle: no sync, clock on
    assign sync_any = |(i_lane_sync & LANE_ENABLE);
    assign rc_all   = &(i_rate_change_on | ~LANE_ENABLE);

    always_ff @(posedge clk or negedge i_pll_done_0) begin
        if (!i_pll_done_0) begin
            sync_ff               <= 1'b0;
            o_lane_sync           <= 1'b0;
            rc_ff                 <= 1'b1;
            o_rate_change_tclk_on <= 1'b1;
        end else begin
            sync_ff               <= sync_any;
            o_lane_sync           <= sync_ff;
            rc_ff                 <= rc_all;
            o_rate_change_tclk_on <= rc_ff;
        end
    end

endmodule

`default_nettype wire

// File: verilog/tx_rst_top.sv
/* Tx reset sequencer top */

`timescale 1ns/1ps
`default_nettype none

module tx_rst_top import tx_rst_types_pkg::*; #(
    parameter lane_vec_t LANE_ENABLE     = '1,
    parameter int        LOCK_DEB_CYCLES = 2048,
    parameter ckdiv_t    DEFAULT_CKDIV   = '0
) (
    input  wire                           clk,
    input  wire                           i_pll_done_0,
    input  wire lane_vec_t                i_txlane_rst,
    input  wire lane_vec_t                i_tx_rate_chng,
    input  wire lane_vec_t                i_pll_lock_tx,
    input  wire ckdiv_t [NUM_LANES-1:0]   i_txckdiv,
    output wire lane_vec_t                o_txlane_done,
    output wire lane_vec_t                o_txckdiv_done,
    output wire lane_vec_t                o_tx_pd_clkpath,
    output wire lane_vec_t                o_tx_pd_driver,
    output wire lane_vec_t                o_tx_pd_piso,
    output wire ckdiv_t [NUM_LANES-1:0]   o_tx_rate,
    output wire lane_vec_t                o_tx_pma_rst,
    output wire lane_vec_t                o_pcs_tx_rst,
    output wire                           o_lane_sync,
    output wire                           o_rate_change_tclk_on
);

    wire lane_vec_t lane_sync;
    wire lane_vec_t rate_change_on;

    ////////////////////////////////////////
    // Lanes
    ////////////////////////////////////////

    for (genvar ln = 0; ln < NUM_LANES; ln++) begin : g_lane
        if (LANE_ENABLE[ln]) begin : g_on
            wire lane_rstn;
            wire lock_deb;
            wire rate_req;

            hsst_tx_lane_if lane_if ();

            lane_input_cond #(
                .LOCK_DEB_CYCLES (LOCK_DEB_CYCLES)
            ) u_cond (
                .clk            (clk),
                .i_pll_done_0   (i_pll_done_0),
                .i_txlane_rst   (i_txlane_rst[ln]),
                .i_pll_lock_tx  (i_pll_lock_tx[ln]),
                .i_tx_rate_chng (i_tx_rate_chng[ln]),
                .o_lane_rstn    (lane_rstn),
                .o_lock_deb     (lock_deb),
                .o_rate_req     (rate_req)
            );

            txlane_rst_fsm #(
                .DEFAULT_CKDIV (DEFAULT_CKDIV)
            ) u_fsm (
                .clk            (clk),
                .i_rst_n        (lane_rstn),
                .i_lock_deb     (lock_deb),
                .i_rate_req     (rate_req),
                .i_txckdiv      (i_txckdiv[ln]),
                .o_txlane_done  (o_txlane_done[ln]),
                .o_txckdiv_done (o_txckdiv_done[ln]),
                .lane           (lane_if)
            );

            assign o_tx_pd_clkpath[ln] = lane_if.pd_clkpath;
            assign o_tx_pd_driver[ln]  = lane_if.pd_driver;
            assign o_tx_pd_piso[ln]    = lane_if.pd_piso;
            assign o_tx_rate[ln]       = lane_if.tx_rate;
            assign o_tx_pma_rst[ln]    = lane_if.pma_rst;
            assign o_pcs_tx_rst[ln]    = lane_if.pcs_rst;
            assign lane_sync[ln]       = lane_if.lane_sync;
            assign rate_change_on[ln]  = lane_if.rate_change_on;
        end else begin : g_off
            // Lane held powered down and in reset
            assign o_txlane_done[ln]   = 1'b0;
            assign o_txckdiv_done[ln]  = 1'b0;
            assign o_tx_pd_clkpath[ln] = 1'b1;
            assign o_tx_pd_driver[ln]  = 1'b1;
            assign o_tx_pd_piso[ln]    = 1'b1;
            assign o_tx_rate[ln]       = DEFAULT_CKDIV;
            assign o_tx_pma_rst[ln]    = 1'b1;
            assign o_pcs_tx_rst[ln]    = 1'b1;
            assign lane_sync[ln]       = 1'b0;
            assign rate_change_on[ln]  = 1'b1;
        end
    end

    ////////////////////////////////////////
    // PLL0 flags
    ////////////////////////////////////////

    pll_sync_combine #(
        .LANE_ENABLE (LANE_ENABLE)
    ) u_pll0_combine (
        .clk                   (clk),
        .i_pll_done_0          (i_pll_done_0),
        .i_lane_sync           (lane_sync),
        .i_rate_change_on      (rate_change_on),
        .o_lane_sync           (o_lane_sync),
        .o_rate_change_tclk_on (o_rate_change_tclk_on)
    );

endmodule

`default_nettype wire

// File: include/tb_tx_rst_checks.svh
/* Testbench compare tasks */

`ifndef TB_TX_RST_CHECKS_SVH
`define TB_TX_RST_CHECKS_SVH

task automatic check_bit(input string tname, input string what,
                         input logic exp, input logic act);
    chk_cnt++;
    if (act !== exp) begin
        err_cnt++;
        $display("ERR %s: %s expected %b actual %b", tname, what, exp, act);
    end
endtask

task automatic check_lanes(input string tname, input string what,
                           input lane_vec_t exp, input lane_vec_t act);
    chk_cnt++;
    if (act !== exp) begin
        err_cnt++;
        $display("ERR %s: %s expected %h actual %h", tname, what, exp, act);
    end
endtask

task automatic check_rate(input string tname, input string what,
                          input ckdiv_t exp, input ckdiv_t act);
    chk_cnt++;
    if (act !== exp) begin
        err_cnt++;
        $display("ERR %s: %s expected %0d actual %0d", tname, what, exp, act);
    end
endtask

task automatic report_fault(input string tname, input string msg);
    flt_cnt++;
    $display("%s: %s", tname, msg);
endtask

////////////////////////////////////////
// Grouped checks
////////////////////////////////////////

task automatic check_lane_pd(input string tname, input int ln, input logic exp);
    check_bit(tname, $sformatf("pd_clkpath[%0d]", ln), exp, pd_clkpath[ln]);
    check_bit(tname, $sformatf("pd_driver[%0d]", ln), exp, pd_driver[ln]);
    check_bit(tname, $sformatf("pd_piso[%0d]", ln), exp, pd_piso[ln]);
endtask

task automatic check_lane_rst(input string tname, input int ln, input logic exp);
    check_bit(tname, $sformatf("pma_rst[%0d]", ln), exp, pma_rst[ln]);
    check_bit(tname, $sformatf("pcs_rst[%0d]", ln), exp, pcs_rst[ln]);
endtask

task automatic check_reset_state(input string tname);
    check_lanes(tname, "pd_clkpath", '1, pd_clkpath);
    check_lanes(tname, "pd_driver", '1, pd_driver);
    check_lanes(tname, "pd_piso", '1, pd_piso);
    check_lanes(tname, "pma_rst", '1, pma_rst);
    check_lanes(tname, "pcs_rst", '1, pcs_rst);
    check_lanes(tname, "txlane_done", '0, txlane_done);
    check_lanes(tname, "txckdiv_done", '0, txckdiv_done);
    check_bit(tname, "lane_sync", 1'b0, lane_sync);
    check_bit(tname, "rate_change_tclk_on", 1'b1, rc_tclk_on);
endtask

// Done flags, all rates, and the removed lanes
task automatic check_outputs(input string tname, input int idx);
    check_lanes(tname, "txlane_done", c_done[idx], txlane_done);
    check_lanes(tname, "txckdiv_done", c_ckdone[idx], txckdiv_done);
    for (int k = 0; k < NUM_LANES; k++) begin
        check_rate(tname, $sformatf("tx_rate[%0d]", k), rate_model[k], tx_rate[k]);
    end
    check_lanes(tname, "pd_clkpath off lanes", ~LANE_EN, pd_clkpath & ~LANE_EN);
    check_lanes(tname, "pd_driver off lanes", ~LANE_EN, pd_driver & ~LANE_EN);
    check_lanes(tname, "pd_piso off lanes", ~LANE_EN, pd_piso & ~LANE_EN);
    check_lanes(tname, "pma_rst off lanes", ~LANE_EN, pma_rst & ~LANE_EN);
    check_lanes(tname, "pcs_rst off lanes", ~LANE_EN, pcs_rst & ~LANE_EN);
endtask

`endif

// File: verif/tb_tx_rst.sv
/* Tx reset sequencer testbench */

`timescale 1ns/1ps
`default_nettype none

module tb_tx_rst import tx_rst_types_pkg::*; ();

    localparam lane_vec_t LANE_EN   = 4'b0111;
    localparam int        DEB_CYC   = 32;
    localparam ckdiv_t    DEF_CKDIV = 3'd2;
    localparam int        WD_MARGIN = 100;

    logic                   clk;
    logic                   pll_done_0;
    lane_vec_t              txlane_rst;
    lane_vec_t              rate_chng;
    lane_vec_t              pll_lock;
    ckdiv_t [NUM_LANES-1:0] txckdiv;
    wire lane_vec_t         txlane_done;
    wire lane_vec_t         txckdiv_done;
    wire lane_vec_t         pd_clkpath;
    wire lane_vec_t         pd_driver;
    wire lane_vec_t         pd_piso;
    wire ckdiv_t [NUM_LANES-1:0] tx_rate;
    wire lane_vec_t         pma_rst;
    wire lane_vec_t         pcs_rst;
    wire                    lane_sync;
    wire                    rc_tclk_on;

    int        err_cnt;
    int        chk_cnt;
    int        flt_cnt;
    logic      loaded;
    logic      sync_seen;
    logic      rc_low_seen;
    ckdiv_t    rate_model [NUM_LANES];
    string     c_name [$];
    string     c_op [$];
    int        c_lane [$];
    ckdiv_t    c_rate [$];
    lane_vec_t c_done [$];
    lane_vec_t c_ckdone [$];
    ckdiv_t    c_exp_rate [$];
    int        c_bound [$];

    `include "tb_tx_rst_checks.svh"

    tx_rst_top #(
        .LANE_ENABLE     (LANE_EN),
        .LOCK_DEB_CYCLES (DEB_CYC),
        .DEFAULT_CKDIV   (DEF_CKDIV)
    ) uut (
        .clk                   (clk),
        .i_pll_done_0          (pll_done_0),
        .i_txlane_rst          (txlane_rst),
        .i_tx_rate_chng        (rate_chng),
        .i_pll_lock_tx         (pll_lock),
        .i_txckdiv             (txckdiv),
        .o_txlane_done         (txlane_done),
        .o_txckdiv_done        (txckdiv_done),
        .o_tx_pd_clkpath       (pd_clkpath),
        .o_tx_pd_driver        (pd_driver),
        .o_tx_pd_piso          (pd_piso),
        .o_tx_rate             (tx_rate),
        .o_tx_pma_rst          (pma_rst),
        .o_pcs_tx_rst          (pcs_rst),
        .o_lane_sync           (lane_sync),
        .o_rate_change_tclk_on (rc_tclk_on)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // Sticky flags for pulses between checks
    always @(negedge clk) begin
        if (lane_sync === 1'b1) begin
            sync_seen = 1'b1;
        end
        if (rc_tclk_on === 1'b0) begin
            rc_low_seen = 1'b1;
        end
    end

    ////////////////////////////////////////
    // Stimulus helpers
    ////////////////////////////////////////

    task automatic next_cycle();
        @(posedge clk);
        #1;
    endtask

    // used is -1 when the bound runs out
    task automatic wait_done(input int ln, input logic level, input int bound, output int used);
        used = -1;
        for (int i = 1; i <= bound; i++) begin
            next_cycle();
            if (txlane_done[ln] === level) begin
                used = i;
                break;
            end
        end
    endtask

    task automatic run_case(input int idx);
        string tname;
        int    ln;
        int    used;
        int    used2;
        tname       = c_name[idx];
        ln          = c_lane[idx];
        sync_seen   = 1'b0;
        rc_low_seen = 1'b0;
        if (c_op[idx] == "reset") begin
            pll_done_0 = 1'b0;
            txlane_rst = '0;
            rate_chng  = '0;
            pll_lock   = '0;
            for (int k = 0; k < NUM_LANES; k++) begin
                rate_model[k] = LANE_EN[k] ? c_exp_rate[idx] : DEF_CKDIV;
            end
            repeat (3) begin
                next_cycle();
                check_reset_state(tname);
            end
            pll_done_0 = 1'b1;
            next_cycle();
            check_reset_state(tname);
            check_outputs(tname, idx);
        end else if (c_op[idx] == "lock") begin
            pll_lock[ln] = 1'b1;
            wait_done(ln, 1'b1, c_bound[idx], used);
            if (used < 0) begin
                report_fault(tname, "lane done did not rise within the bound");
            end
            check_bit(tname, "o_lane_sync seen high", 1'b1, sync_seen);
            check_lane_pd(tname, ln, 1'b0);
            check_lane_rst(tname, ln, 1'b0);
            rate_model[ln] = c_exp_rate[idx];
            check_outputs(tname, idx);
        end else if (c_op[idx] == "rate") begin
            txckdiv[ln]   = c_rate[idx];
            rate_chng[ln] = 1'b1;
            wait_done(ln, 1'b0, c_bound[idx], used);
            if (used < 0) begin
                report_fault(tname, "lane done did not drop after the rate request");
            end else begin
                wait_done(ln, 1'b1, c_bound[idx] - used, used2);
                if (used2 < 0) begin
                    report_fault(tname, "lane done did not return after the rate change");
                end
            end
            check_bit(tname, "rate_change_tclk_on seen low", 1'b1, rc_low_seen);
            rate_model[ln] = c_exp_rate[idx];
            check_outputs(tname, idx);
            rate_chng[ln] = 1'b0;
            repeat (4) next_cycle();
        end else if (c_op[idx] == "unlock") begin
            pll_lock[ln] = 1'b0;
            wait_done(ln, 1'b0, c_bound[idx], used);
            if (used < 0) begin
                report_fault(tname, "lane done stayed high after lock loss");
            end
            check_lane_rst(tname, ln, 1'b1);
            check_outputs(tname, idx);
        end else if (c_op[idx] == "lanerst") begin
            txlane_rst[ln] = 1'b1;
            next_cycle();
            check_lane_pd(tname, ln, 1'b1);
            check_lane_rst(tname, ln, 1'b1);
            rate_model[ln] = c_exp_rate[idx];
            check_outputs(tname, idx);
            next_cycle();
            txlane_rst[ln] = 1'b0;
        end else begin
            report_fault(tname, "unknown operation in the cases file");
        end
    endtask

    ////////////////////////////////////////
    // Main sequence
    ////////////////////////////////////////

    initial begin
        int    fd;
        int    rc;
        string line;
        string nm;
        string op;
        int    ln;
        int    rt;
        int    ed;
        int    ec;
        int    er;
        int    bd;
        err_cnt     = 0;
        chk_cnt     = 0;
        flt_cnt     = 0;
        loaded      = 1'b0;
        sync_seen   = 1'b0;
        rc_low_seen = 1'b0;
        pll_done_0  = 1'b0;
        txlane_rst  = '0;
        rate_chng   = '0;
        pll_lock    = '0;
        txckdiv     = '0;
        for (int k = 0; k < NUM_LANES; k++) begin
            rate_model[k] = DEF_CKDIV;
        end
        fd = $fopen("verif/tx_rst_cases.txt", "r");
        if (fd == 0) begin
            report_fault("setup", "cannot open verif/tx_rst_cases.txt");
        end
        while (fd != 0 && !$feof(fd)) begin
            line = "";
            rc   = $fgets(line, fd);
            if (rc > 0 && line.len() > 1 && line.getc(0) != "#") begin
                rc = $sscanf(line, "%s %s %d %d %h %h %d %d", nm, op, ln, rt, ed, ec, er, bd);
                if (rc == 8) begin
                    c_name.push_back(nm);
                    c_op.push_back(op);
                    c_lane.push_back(ln);
                    c_rate.push_back(ckdiv_t'(rt));
                    c_done.push_back(lane_vec_t'(ed));
                    c_ckdone.push_back(lane_vec_t'(ec));
                    c_exp_rate.push_back(ckdiv_t'(er));
                    c_bound.push_back(bd);
                end else begin
                    report_fault("setup", "malformed line in the cases file");
                end
            end
        end
        if (fd != 0) begin
            $fclose(fd);
        end
        if (c_name.size() == 0) begin
            report_fault("setup", "no cases were loaded");
        end
        loaded = 1'b1;
        for (int i = 0; i < c_name.size(); i++) begin
            run_case(i);
        end
        $display("Summary: %0d cases, %0d checks, %0d value errors, %0d other failures",
                 c_name.size(), chk_cnt, err_cnt, flt_cnt);
        if (err_cnt == 0 && flt_cnt == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

    // Limit from the sum of the per-case bounds
    initial begin
        int wd_cycles;
        wait (loaded === 1'b1);
        wd_cycles = WD_MARGIN;
        for (int i = 0; i < c_bound.size(); i++) begin
            wd_cycles += c_bound[i] + 10;
        end
        repeat (wd_cycles) @(posedge clk);
        $display("Watchdog expired after %0d cycles before all cases finished", wd_cycles);
        $display("Test failed");
        $finish;
    end

endmodule

`default_nettype wire

// File: verif/tx_rst_cases.txt
# name op lane rate exp_done exp_ckdiv_done exp_rate bound
# done vectors in hex, lane rate and bound (clk cycles) in decimal
por        reset   0 0 0 0 2 10
up_l0      lock    0 0 1 0 2 90
up_l1      lock    1 0 3 0 2 90
up_l2      lock    2 0 7 0 2 90
rate_l1    rate    1 5 7 2 5 60
rate_l1b   rate    1 3 7 2 3 60
rate_l2    rate    2 6 7 6 6 60
unlock_l2  unlock  2 0 3 6 6 20
relock_l2  lock    2 0 7 6 6 90
rst_l1     lanerst 1 0 5 4 2 10
relock_l1  lock    1 0 7 4 2 90

// File: flist.f
+incdir+include
verilog/tx_rst_types_pkg.sv
verilog/tx_rst_timing_pkg.sv
verilog/hsst_tx_lane_if.sv
verilog/lane_input_cond.sv
verilog/txlane_rst_fsm.sv
verilog/pll_sync_combine.sv
verilog/tx_rst_top.sv
verif/tb_tx_rst.sv

// File: Makefile
TOOL  = verilator
FLAGS = --binary --timing --assert -Wno-fatal
TOP   = tb_tx_rst
FLIST = flist.f
LOG   = sim.log

.PHONY: sim clean

sim:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FLIST)
	./obj_dir/V$(TOP) | tee $(LOG)
	@if grep -q "Test failed" $(LOG); then exit 1; fi
	@grep -q "Test passed" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
